/* qspi_flash.f */
src/qspi_pkg.sv
src/qspi_bit_timer.sv
src/qspi_sequencer.sv
src/qspi_shifter.sv
src/qspi_flash.sv
sim/qspi_flash_model.sv
sim/qspi_flash_asserts.sv
sim/tb_qspi_flash.sv

/* Makefile */
# Verilator build and run for the QSPI flash read engine

TOP = tb_qspi_flash
OBJ = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f qspi_flash.f -Mdir $(OBJ) -o sim_$(TOP)

run: compile
	./$(OBJ)/sim_$(TOP) | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf $(OBJ) sim.log

/* sim/tb_qspi_flash.sv */
/*
 * Testbench for the QSPI flash read engine.
 * Runs setup, quad streaming, address changes, aborted reads and the
 * serial fallback against the flash model; every byte is checked.
 */
`timescale 1ns/1ns

module tb_qspi_flash;
    import qspi_pkg::*;

    logic        clk;
    logic        rst;
    flash_addr_t addr;
    logic        do_read;
    logic        setup_done;
    logic        data_ready;
    flash_byte_t data;
    logic        sclk;
    logic        cs;
    logic [3:0]  io_out;
    logic [3:0]  io_oe;
    logic [3:0]  io_in;
    flash_byte_t model_vendor;
    logic        quad_active;
    logic [15:0] sr_word;
    logic        sr_written;
    int          eb_count;

    integer      seed;
    int          errors;
    int          failed;
    int          cycle;
    string       test_name;
    flash_addr_t track_addr;     // Address of the next expected byte
    int          byte_count;
    logic        first_of_read;
    int          last_pulse;
    int          expected_gap;

    qspi_flash i_qspi_flash (
        .clk(clk), .rst(rst), .addr(addr), .do_read(do_read),
        .setup_done(setup_done), .data_ready(data_ready), .data(data),
        .sclk(sclk), .cs(cs), .io_out(io_out), .io_oe(io_oe), .io_in(io_in)
    );

    qspi_flash_model flash (
        .rst(rst), .sclk(sclk), .cs(cs), .io_out(io_out), .io_oe(io_oe), .io_in(io_in),
        .vendor_id(model_vendor), .quad_active(quad_active), .sr_word(sr_word),
        .sr_written(sr_written), .eb_count(eb_count)
    );

    always #20 clk = ~clk;
    always @(posedge clk) cycle <= cycle + 1;

    function automatic flash_byte_t expected_byte(input flash_addr_t a);
        return a[7:0] ^ a[15:8];
    endfunction

    task automatic check_byte(input string what, input flash_byte_t exp, input flash_byte_t act);
        if (act !== exp) begin
            errors++;
            $display("** Error %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("** Error %s %s: expected %b, actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic check_gap(input string what, input int exp, input int act);
        if (act != exp) begin
            errors++;
            $display("** Error %s %s: expected %0d, actual %0d", test_name, what, exp, act);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $finish;
    endtask

    // Compare every byte at the falling clk edge where outputs are stable
    always @(negedge clk) begin
        if (!rst && data_ready) begin
            if (!do_read) begin
                errors++;
                $display("%s: data_ready arrived while do_read was low", test_name);
            end
            check_byte("read data", expected_byte(track_addr), data);
            if (!first_of_read)
                check_gap("data_ready spacing", expected_gap, cycle - last_pulse);
            first_of_read = 1'b0;
            last_pulse    = cycle;
            track_addr    = track_addr + 1'b1;
            byte_count++;
        end
    end

    task automatic apply_reset();
        rst     = 1'b1;
        do_read = 1'b0;
        repeat (16) @(posedge clk);
        #5 rst = 1'b0;
    endtask

    task automatic wait_setup();
        int n;
        n = 0;
        while (!setup_done) begin
            @(negedge clk);
            n++;
            if (n > 4000)
                abort_run("Timed out waiting for setup_done");
        end
    endtask

    task automatic wait_bytes(input int target);
        int n;
        n = 0;
        while (byte_count < target) begin
            @(posedge clk);
            n++;
            if (n > 200 + 20 * target)
                abort_run("Timed out waiting for data_ready");
        end
    endtask

    task automatic start_read(input flash_addr_t a);
        @(posedge clk);
        #5;
        addr          = a;
        do_read       = 1'b1;
        track_addr    = a;
        first_of_read = 1'b1;
        byte_count    = 0;
    endtask

    task automatic read_burst(input flash_addr_t a, input int n);
        start_read(a);
        wait_bytes(n);
        @(posedge clk);
        #5 do_read = 1'b0;
    endtask

    task automatic report_test(input int num, input int err0);
        if (errors == err0) begin
            $display("Test %0d %s: ok", num, test_name);
        end else begin
            failed++;
            $display("Test %0d %s: failed with %0d errors", num, test_name, errors - err0);
        end
    endtask

    initial begin
        flash_addr_t a;
        int          err0;
        seed = 45;
        clk = 1'b0;
        rst = 1'b1;
        addr = '0;
        do_read = 1'b0;
        model_vendor = VENDOR_ID;
        errors = 0;
        failed = 0;
        cycle = 0;
        byte_count = 0;
        first_of_read = 1'b1;
        last_pulse = 0;
        expected_gap = 4;
        track_addr = '0;

        test_name = "setup";
        err0 = errors;
        apply_reset();
        check_flag("setup_done after reset", 1'b0, setup_done);
        wait_setup();
        check_flag("status write under WEL", 1'b1, sr_written);
        check_byte("status byte 1", 8'h80, sr_word[15:8]);
        check_byte("status byte 2", 8'h02, sr_word[7:0]);
        check_flag("continuous quad mode", 1'b1, quad_active);
        report_test(1, err0);

        test_name = "quad stream";
        err0 = errors;
        a = flash_addr_t'($random(seed));
        read_burst(a, 32);
        report_test(2, err0);

        test_name = "address change";
        err0 = errors;
        repeat (3) begin
            a = flash_addr_t'($random(seed));
            read_burst(a, 6);
        end
        check_flag("no EB after setup", 1'b1, eb_count == 1);
        report_test(3, err0);

        test_name = "abort mid byte";
        err0 = errors;
        a = flash_addr_t'($random(seed));
        start_read(a);
        wait_bytes(3);
        repeat (2) @(posedge clk);
        #5 do_read = 1'b0;
        repeat (3) @(posedge clk);
        read_burst(a + 24'd100, 4);
        report_test(4, err0);

        test_name = "serial fallback";
        err0 = errors;
        model_vendor = 8'hC2;    // Unknown vendor
        apply_reset();
        wait_setup();
        check_flag("continuous quad mode", 1'b0, quad_active);
        expected_gap = 16;
        repeat (2) begin
            a = flash_addr_t'($random(seed));
            read_burst(a, 8);
        end
        report_test(5, err0);

        $display("Summary: 5 tests, %0d failed, %0d errors", failed, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* sim/qspi_flash_asserts.sv */
/*
 * Pin and strobe checks for the QSPI flash engine.
 * Bound to every qspi_flash instance from the bottom of this file.
 */
`timescale 1ns/1ns

module qspi_flash_asserts (
    input logic       clk,
    input logic       rst,
    input logic       cs,
    input logic       do_read,
    input logic       data_ready,
    input logic [3:0] io_out,
    input logic [3:0] io_oe
);

    // Chip select cooldown between transfers
    cs_min_high: assert property (@(posedge clk) disable iff (rst)
        $rose(cs) |=> cs ##1 cs)
        else $error("cs high for less than the cooldown");

    no_ready_without_read: assert property (@(posedge clk) disable iff (rst)
        !do_read |-> !data_ready)
        else $error("data_ready while do_read is low");

    wp_low_when_idle: assert property (@(posedge clk) disable iff (rst)
        cs |-> (io_oe[2] && !io_out[2]))
        else $error("wp not driven low while cs is high");

endmodule

bind qspi_flash qspi_flash_asserts i_asserts (
    .clk(clk), .rst(rst), .cs(cs), .do_read(do_read),
    .data_ready(data_ready), .io_out(io_out), .io_oe(io_oe)
);

/* sim/qspi_flash_model.sv */
/*
 * Behavioral QSPI flash chip for the testbench.
 * Answers JEDEC ID, write enable, status writes, fast read and continuous
 * quad read; memory content is the low address byte XOR the middle byte.
 */
`timescale 1ns/1ns

module qspi_flash_model
    import qspi_pkg::*;
(
    input  logic        rst,
    input  logic        sclk,
    input  logic        cs,
    input  logic [3:0]  io_out,
    input  logic [3:0]  io_oe,
    output logic [3:0]  io_in,
    input  flash_byte_t vendor_id,
    output logic        quad_active,
    output logic [15:0] sr_word,
    output logic        sr_written,
    output int          eb_count
);

    localparam flash_byte_t DEVICE_BYTE = 8'h85;

    logic [3:0]  flash_out;
    logic [3:0]  flash_oe;
    logic [3:0]  line;        // Resolved pin view, pulled up when nobody drives
    flash_byte_t cmd;
    int          bits;        // Rising sclk edges in this cs-low session
    flash_addr_t rd_addr;
    flash_byte_t mode;
    logic [15:0] sr_shift;
    logic        wel;

    assign line  = (io_oe & io_out) | (~io_oe & flash_oe & flash_out) | (~io_oe & ~flash_oe);
    assign io_in = line;

    function automatic flash_byte_t byte_at(input flash_addr_t a);
        return a[15:8] ^ a[7:0];
    endfunction

    task automatic power_up();
        quad_active = 1'b0;
        sr_word     = '0;
        sr_written  = 1'b0;
        eb_count    = 0;
        wel         = 1'b0;
        flash_oe    = '0;
        flash_out   = '0;
        cmd         = '0;
        bits        = 0;
    endtask

    initial power_up();
    always @(posedge rst) power_up();

    always @(negedge cs) begin
        flash_oe = '0;
        sr_shift = '0;
        if (quad_active) begin   // Continuous mode skips the opcode
            cmd  = OP_QUAD_READ;
            bits = 8;
        end else begin
            cmd  = '0;
            bits = 0;
        end
    end

    always @(posedge cs) begin
        flash_oe = '0;
        if (bits == 8 && cmd == OP_WRITE_EN)
            wel = 1'b1;
        if (bits == 8 && cmd == OP_WRITE_DIS)
            wel = 1'b0;
        if (bits == 24 && cmd == OP_WRITE_SR) begin
            if (wel) begin
                sr_word    = sr_shift;
                sr_written = 1'b1;
            end
            wel = 1'b0;
        end
        bits = 0;
        cmd  = '0;
    end

    always @(posedge sclk) begin
        if (!cs) begin
            bits = bits + 1;
            if (bits <= 8) begin
                cmd = {cmd[6:0], line[0]};
                if (bits == 8 && cmd == OP_QUAD_READ)
                    eb_count = eb_count + 1;
            end else if (cmd == OP_WRITE_SR && bits <= 24) begin
                sr_shift = {sr_shift[14:0], line[0]};
            end else if (cmd == OP_FAST_READ && bits <= 32) begin
                rd_addr = {rd_addr[22:0], line[0]};
            end else if (cmd == OP_QUAD_READ && bits <= 14) begin
                rd_addr = {rd_addr[19:0], line};
            end else if (cmd == OP_QUAD_READ && bits <= 16) begin
                mode = {mode[3:0], line};
                if (bits == 16)
                    quad_active = (mode == MODE_CONTINUOUS);
            end
        end
    end

    // Outputs change on the falling sclk edge
    always @(negedge sclk) begin
        int          idx;
        flash_byte_t b;
        logic [15:0] id_word;
        id_word = {vendor_id, DEVICE_BYTE};
        if (!cs) begin
            if (cmd == OP_READ_ID && bits >= 8 && bits < 24) begin
                idx       = bits - 8;
                flash_oe  = 4'b0010;
                flash_out = {2'b00, id_word[15 - idx], 1'b0};
            end else if (cmd == OP_FAST_READ && bits >= 40) begin
                idx       = bits - 40;
                b         = byte_at(rd_addr + flash_addr_t'(idx / 8));
                flash_oe  = 4'b0010;
                flash_out = {2'b00, b[7 - (idx % 8)], 1'b0};
            end else if (cmd == OP_QUAD_READ && bits >= 20) begin
                idx       = bits - 20;    // Four dummy clocks already passed
                b         = byte_at(rd_addr + flash_addr_t'(idx / 2));
                flash_oe  = 4'b1111;
                flash_out = (idx % 2 == 1) ? b[3:0] : b[7:4];
            end else begin
                flash_oe = '0;
            end
        end
    end

endmodule

/* src/qspi_flash.sv */
/*
 * QSPI flash read engine, top level.
 * Wait for setup_done, then hold addr and keep do_read high to stream
 * bytes, one per data_ready pulse. Drop do_read for a cycle to change addr.
 * Data lines leave as separate out, enable and in vectors.
 */
`timescale 1ns/1ns

module qspi_flash
    import qspi_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  flash_addr_t addr,
    input  logic        do_read,
    output logic        setup_done,
    output logic        data_ready,
    output flash_byte_t data,
    output logic        sclk,
    output logic        cs,
    output logic [3:0]  io_out,
    output logic [3:0]  io_oe,
    input  logic [3:0]  io_in
);

    logic        start;
    bit_count_t  bit_count;
    logic        quad;
    logic        cs_release;
    logic        xfer_done;
    logic        cooldown_busy;
    logic        shift_edge;
    logic        sample_edge;
    shift_ctrl_t ctrl;
    flash_byte_t rx_byte;
    logic        rx_strobe;

    qspi_sequencer i_sequencer (
        .clk(clk), .rst(rst), .addr(addr), .do_read(do_read),
        .xfer_done(xfer_done), .cooldown_busy(cooldown_busy),
        .rx_byte(rx_byte), .rx_strobe(rx_strobe),
        .start(start), .bit_count(bit_count), .quad(quad), .cs_release(cs_release),
        .ctrl(ctrl), .setup_done(setup_done), .data_ready(data_ready), .data(data)
    );

    qspi_bit_timer i_bit_timer (
        .clk(clk), .rst(rst), .start(start), .bit_count(bit_count), .quad(quad),
        .cs_release(cs_release), .sclk(sclk), .cs(cs), .shift_edge(shift_edge),
        .sample_edge(sample_edge), .xfer_done(xfer_done), .cooldown_busy(cooldown_busy)
    );

    qspi_shifter i_shifter (
        .clk(clk), .rst(rst), .ctrl(ctrl), .shift_edge(shift_edge),
        .sample_edge(sample_edge), .cs(cs), .io_in(io_in), .io_out(io_out),
        .io_oe(io_oe), .rx_byte(rx_byte), .rx_strobe(rx_strobe)
    );

endmodule

/* src/qspi_shifter.sv */
/*
 * Data line driver and receive byte assembler.
 * Loads a 40-bit payload from the sequencer and shifts it out MSB first,
 * one bit on si or one nibble on all four lines per serial clock.
 * Received bits are collected into bytes with a strobe per full byte.
 */
`timescale 1ns/1ns

module qspi_shifter
    import qspi_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  shift_ctrl_t ctrl,
    input  logic        shift_edge,
    input  logic        sample_edge,
    input  logic        cs,
    input  logic [3:0]  io_in,
    output logic [3:0]  io_out,
    output logic [3:0]  io_oe,
    output flash_byte_t rx_byte,
    output logic        rx_strobe
);

    logic [39:0] send_sr;
    flash_byte_t rx_sr;
    logic        quad_q;
    logic        drive_q;
    logic        capture_q;
    logic [3:0]  rx_bits;    // Bits gathered in the current byte
    logic [3:0]  rx_step;

    assign rx_step = quad_q ? 4'd4 : 4'd1;
    assign rx_byte = rx_sr;

    // Line order is {hold, wp, so, si}
    always_comb begin
        if (cs) begin
            io_oe  = 4'b0100;     // Keep write protect asserted while idle
            io_out = 4'b0000;
        end else if (!drive_q) begin
            io_oe  = 4'b0000;     // Flash owns the lines, or dummy steps
            io_out = 4'b0000;
        end else if (quad_q) begin
            io_oe  = 4'b1111;
            io_out = send_sr[39:36];
        end else begin
            io_oe  = 4'b0001;
            io_out = {3'b000, send_sr[39]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            quad_q    <= 1'b0;
            drive_q   <= 1'b0;
            capture_q <= 1'b0;
            rx_bits   <= '0;
            rx_strobe <= 1'b0;
        end else begin
            rx_strobe <= 1'b0;
            if (ctrl.load) begin
                quad_q    <= ctrl.quad;
                drive_q   <= ctrl.drive;
                capture_q <= ctrl.capture;
                rx_bits   <= '0;
            end else if (cs) begin
                rx_bits <= '0;    // Partial byte dropped on abort
            end else if (sample_edge && capture_q) begin
                if (rx_bits + rx_step == 4'd8) begin
                    rx_bits   <= '0;
                    rx_strobe <= 1'b1;
                end else begin
                    rx_bits <= rx_bits + rx_step;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.load)
            send_sr <= ctrl.payload;
        else if (shift_edge)
            send_sr <= quad_q ? {send_sr[35:0], 4'h0} : {send_sr[38:0], 1'b0};

        if (sample_edge && capture_q)
            rx_sr <= quad_q ? {rx_sr[3:0], io_in} : {rx_sr[6:0], io_in[1]};  // so in serial
    end

endmodule

/* src/qspi_sequencer.sv */
/*
 * Setup and read FSM of the QSPI flash engine.
 * Runs wake, ID check and quad enable after reset, then serves host reads
 * in continuous quad mode or, for an unknown chip, with serial fast read.
 * Outputs toward the timer and shifter are combinational so transfers chain.
 */
`timescale 1ns/1ns

module qspi_sequencer
    import qspi_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  flash_addr_t addr,
    input  logic        do_read,
    input  logic        xfer_done,
    input  logic        cooldown_busy,
    input  flash_byte_t rx_byte,
    input  logic        rx_strobe,
    output logic        start,
    output bit_count_t  bit_count,
    output logic        quad,
    output logic        cs_release,
    output shift_ctrl_t ctrl,
    output logic        setup_done,
    output logic        data_ready,
    output flash_byte_t data
);

    seq_state_t  state, state_nx;
    seq_state_t  resume, resume_nx;   // Where to go once cs has cooled down
    logic [1:0]  phase, phase_nx;     // Sub-transfer within a state
    logic        quad_ok;
    logic        id_first;            // Next ID byte is the vendor byte
    logic        id_match;
    logic        setup_q;
    flash_byte_t short_op;
    seq_state_t  short_next;

    function automatic shift_ctrl_t make_ctrl(input logic [39:0] payload,
                                              input logic q,
                                              input logic d,
                                              input logic c);
        shift_ctrl_t w;
        w.load    = 1'b1;
        w.payload = payload;
        w.quad    = q;
        w.drive   = d;
        w.capture = c;
        return w;
    endfunction

    assign id_match   = quad_ok && (rx_byte[7:5] == DEVICE_FAMILY);
    assign quad       = (state == QUAD_ADDR) || (state == QUAD_DATA);
    assign setup_done = setup_q;
    assign data       = rx_byte;
    assign data_ready = rx_strobe && do_read && (state == QUAD_DATA || state == SER_DATA);

    // Single opcode commands
    always_comb begin
        case (state)
            WAKE: begin
                short_op   = OP_WAKE;
                short_next = READ_ID;
            end
            WRITE_EN: begin
                short_op   = OP_WRITE_EN;
                short_next = WRITE_SR;
            end
            default: begin
                short_op   = OP_WRITE_DIS;
                short_next = QUAD_OPEN;
            end
        endcase
    end

    always_comb begin
        state_nx   = state;
        phase_nx   = phase;
        resume_nx  = resume;
        start      = 1'b0;
        cs_release = 1'b0;
        bit_count  = '0;
        ctrl       = '0;
        case (state)
            WAKE, WRITE_EN, WRITE_DIS, WRITE_SR: begin
                if (phase == 2'd0 && !cooldown_busy) begin
                    start    = 1'b1;
                    phase_nx = 2'd1;
                    if (state == WRITE_SR) begin
                        bit_count = 6'd24;
                        ctrl = make_ctrl({OP_WRITE_SR, SR_SETUP_WORD, 16'h0}, 1'b0, 1'b1, 1'b0);
                    end else begin
                        bit_count = 6'd8;
                        ctrl = make_ctrl({short_op, 32'h0}, 1'b0, 1'b1, 1'b0);
                    end
                end else if (phase == 2'd1 && xfer_done) begin
                    cs_release = 1'b1;
                    state_nx   = COOLDOWN;
                    resume_nx  = (state == WRITE_SR) ? WRITE_DIS : short_next;
                end
            end
            READ_ID: begin
                if (phase == 2'd0 && !cooldown_busy) begin
                    start     = 1'b1;
                    bit_count = 6'd8;
                    ctrl      = make_ctrl({OP_READ_ID, 32'h0}, 1'b0, 1'b1, 1'b0);
                    phase_nx  = 2'd1;
                end else if (phase == 2'd1 && xfer_done) begin
                    start     = 1'b1;      // Vendor and device bytes
                    bit_count = 6'd16;
                    ctrl      = make_ctrl('0, 1'b0, 1'b0, 1'b1);
                    phase_nx  = 2'd2;
                end else if (phase == 2'd2 && xfer_done) begin
                    cs_release = 1'b1;
                    state_nx   = COOLDOWN;
                    resume_nx  = id_match ? WRITE_EN : IDLE;
                end
            end
            QUAD_OPEN: begin
                if (phase == 2'd0 && !cooldown_busy) begin
                    start     = 1'b1;
                    bit_count = 6'd8;
                    ctrl      = make_ctrl({OP_QUAD_READ, 32'h0}, 1'b0, 1'b1, 1'b0);
                    phase_nx  = 2'd1;
                end else if (phase == 2'd1 && xfer_done) begin
                    start     = 1'b1;      // Address zero plus mode byte, on four lines
                    bit_count = 6'd32;
                    ctrl      = make_ctrl({24'h0, MODE_CONTINUOUS, 8'h0}, 1'b1, 1'b1, 1'b0);
                    state_nx  = QUAD_ADDR;
                    phase_nx  = 2'd0;
                end
            end
            IDLE: begin
                if (do_read && !cooldown_busy) begin
                    start = 1'b1;
                    if (quad_ok) begin
                        bit_count = 6'd32;
                        ctrl      = make_ctrl({addr, MODE_CONTINUOUS, 8'h0}, 1'b1, 1'b1, 1'b0);
                        state_nx  = QUAD_ADDR;
                        phase_nx  = 2'd0;
                    end else begin
                        bit_count = 6'd40;  // Opcode, address and one dummy byte
                        ctrl      = make_ctrl({OP_FAST_READ, addr, 8'h0}, 1'b0, 1'b1, 1'b0);
                        state_nx  = SER_CMD;
                    end
                end
            end
            QUAD_ADDR: begin
                if (setup_q && !do_read) begin
                    cs_release = 1'b1;
                    state_nx   = COOLDOWN;
                    resume_nx  = IDLE;
                end else if (xfer_done && phase == 2'd0) begin
                    start     = 1'b1;      // Dummy steps with the lines released
                    bit_count = bit_count_t'(QUAD_DUMMY_STEPS * 4);
                    ctrl      = make_ctrl('0, 1'b1, 1'b0, 1'b0);
                    phase_nx  = 2'd1;
                end else if (xfer_done && !setup_q) begin
                    cs_release = 1'b1;     // Chip now in continuous mode
                    state_nx   = COOLDOWN;
                    resume_nx  = IDLE;
                end else if (xfer_done) begin
                    start     = 1'b1;
                    bit_count = 6'd8;
                    ctrl      = make_ctrl('0, 1'b1, 1'b0, 1'b1);
                    state_nx  = QUAD_DATA;
                end
            end
            QUAD_DATA, SER_CMD, SER_DATA: begin
                if (!do_read) begin
                    cs_release = 1'b1;
                    state_nx   = COOLDOWN;
                    resume_nx  = IDLE;
                end else if (xfer_done) begin
                    start     = 1'b1;      // Next byte, cs stays low
                    bit_count = 6'd8;
                    ctrl      = make_ctrl('0, quad, 1'b0, 1'b1);
                    state_nx  = (state == SER_CMD) ? SER_DATA : state;
                end
            end
            default: begin
                if (!cooldown_busy) begin
                    state_nx = resume;
                    phase_nx = 2'd0;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= WAKE;
            phase    <= 2'd0;
            resume   <= IDLE;
            quad_ok  <= 1'b0;
            id_first <= 1'b0;
            setup_q  <= 1'b0;
        end else begin
            state  <= state_nx;
            phase  <= phase_nx;
            resume <= resume_nx;
            if (state_nx == IDLE)
                setup_q <= 1'b1;
            if (state == READ_ID && phase == 2'd0)
                id_first <= 1'b1;
            if (state == READ_ID && rx_strobe) begin
                id_first <= 1'b0;
                quad_ok  <= id_first ? (rx_byte == VENDOR_ID) : id_match;
            end
        end
    end

endmodule

/* src/qspi_bit_timer.sv */
/*
 * Serial clock, chip select and bit counter for one flash transfer.
 * A start loads the bit count and drops cs; sclk then toggles every clk.
 * cs_release raises cs at once and starts the cooldown counter.
 */
`timescale 1ns/1ns

module qspi_bit_timer
    import qspi_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  bit_count_t bit_count,
    input  logic       quad,
    input  logic       cs_release,
    output logic       sclk,
    output logic       cs,
    output logic       shift_edge,
    output logic       sample_edge,
    output logic       xfer_done,
    output logic       cooldown_busy
);

    bit_count_t count;      // Bits still to go
    bit_count_t step;
    logic       running;
    logic [1:0] cooldown;

    assign step          = quad ? bit_count_t'(4) : bit_count_t'(1);
    assign running       = (count != '0);
    assign sample_edge   = running && !sclk;   // sclk about to rise
    assign shift_edge    = running && sclk;    // sclk about to fall
    assign xfer_done     = shift_edge && (count == step);
    assign cooldown_busy = (cooldown != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            cs       <= 1'b1;
            sclk     <= 1'b0;
            count    <= '0;
            cooldown <= '0;
        end else begin
            if (cooldown != '0)
                cooldown <= cooldown - 2'd1;

            if (cs_release) begin  // Also aborts a running transfer
                cs       <= 1'b1;
                sclk     <= 1'b0;
                count    <= '0;
                cooldown <= CS_COOLDOWN_CYCLES;
            end else if (start) begin
                cs    <= 1'b0;
                sclk  <= 1'b0;
                count <= bit_count;
            end else if (running) begin
                sclk <= ~sclk;
                if (sclk)
                    count <= count - step;
            end
        end
    end

endmodule

/* src/qspi_pkg.sv */
/*
 * Shared definitions for the QSPI flash read engine.
 * Holds the flash opcodes, identification constants, width types,
 * the sequencer states and the control word passed to the shifter.
 */
package qspi_pkg;

    typedef logic [23:0] flash_addr_t;  // Byte address in the flash
    typedef logic [7:0]  flash_byte_t;  // Data, opcode or ID byte
    typedef logic [5:0]  bit_count_t;   // Bits left in a transfer

    typedef enum logic [3:0] {
        WAKE,
        READ_ID,
        WRITE_EN,
        WRITE_SR,
        WRITE_DIS,
        QUAD_OPEN,
        IDLE,
        QUAD_ADDR,
        QUAD_DATA,
        SER_CMD,
        SER_DATA,
        COOLDOWN
    } seq_state_t;

    // One transfer's setup, latched by the shifter on load
    typedef struct packed {
        logic        load;
        logic [39:0] payload;   // Sent MSB first
        logic        quad;      // Four lines per bit step
        logic        drive;     // Engine owns the data lines
        logic        capture;   // Assemble received bytes
    } shift_ctrl_t;

    localparam flash_byte_t OP_WAKE      = 8'hAB;
    localparam flash_byte_t OP_READ_ID   = 8'h9F;
    localparam flash_byte_t OP_WRITE_EN  = 8'h06;
    localparam flash_byte_t OP_WRITE_SR  = 8'h01;
    localparam flash_byte_t OP_WRITE_DIS = 8'h04;
    localparam flash_byte_t OP_QUAD_READ = 8'hEB;
    localparam flash_byte_t OP_FAST_READ = 8'h0B;

    localparam logic [15:0] SR_SETUP_WORD   = 16'h8002;  // QE set, protections cleared
    localparam flash_byte_t MODE_CONTINUOUS = 8'h20;
    localparam flash_byte_t VENDOR_ID       = 8'h1F;
    localparam logic [2:0]  DEVICE_FAMILY   = 3'b100;    // Top bits of the device byte

    localparam int unsigned QUAD_DUMMY_STEPS   = 4;
    localparam logic [1:0]  CS_COOLDOWN_CYCLES = 2'd2;

endpackage
